// File: filelist.f
+incdir+test
source/uart_pkg.sv
source/sync_fifo.sv
source/uart_tx_framer.sv
source/uart_rx_sampler.sv
source/uart_top.sv
test/tb_uart.sv

// File: test/uart_model.svh
`ifndef UART_MODEL_SVH
`define UART_MODEL_SVH

int       err_cnt  = 0;
int       n_checks = 0;
rx_word_t exp_q[$];   // words the host should read, oldest first
byte_t    line_q[$];  // bytes still to show up on o_tx_serial

// 7-bit mode reads back with bit 7 clear
function automatic byte_t mask_data(byte_t d);
	return size8 ? d : {1'b0, d[6:0]};
endfunction

// even parity gives an even count of ones over data and parity
function automatic logic par_bit(byte_t d);
	return (^mask_data(d)) ^ odd;
endfunction

task automatic check_byte(string name, byte_t got, byte_t exp_v);
	n_checks++;
	if (got !== exp_v) begin
		err_cnt++;
		$display("error at %0t ns: %s got %h expected %h", $time, name, got, exp_v);
	end
endtask

task automatic check_bit(string name, logic got, logic exp_v);
	n_checks++;
	if (got !== exp_v) begin
		err_cnt++;
		$display("error at %0t ns: %s got %b expected %b", $time, name, got, exp_v);
	end
endtask

// accepted write shows up on the line and back at the receiver
task automatic note_write(byte_t d);
	line_q.push_back(mask_data(d));
	exp_q.push_back({1'b0, mask_data(d)});
endtask

// line bits in send order, stop level above the last used bit
task automatic build_frame(input byte_t d, input bit flip, output logic [11:0] bits,
	output int n);
	byte_t m;
	m       = mask_data(d);
	bits    = '1;
	bits[0] = 1'b0;  // start
	n       = 1;
	for (int i = 0; i < (size8 ? 8 : 7); i++) begin
		bits[n] = m[i];
		n++;
	end
	if (parity_en) begin
		bits[n] = par_bit(m) ^ flip;
		n++;
	end
	n = n + 1 + stop2;
endtask

task automatic check_word(rx_word_t got);
	rx_word_t exp_v;
	if (exp_q.size() == 0) begin
		err_cnt++;
		$display("error at %0t ns: received a word that was never sent", $time);
	end else begin
		exp_v = exp_q.pop_front();
		check_byte("o_rx_data", got[7:0], exp_v[7:0]);
		check_bit("o_rx_perr", got[8], exp_v[8]);
	end
endtask

`endif

// File: test/tb_uart.sv
`timescale 1ns/1ns

module tb_uart;

	import uart_pkg::*;

	localparam int FIFO_ADDR_W = 4;
	localparam int CLK_PERIOD  = 40;
	localparam int MAX_DIV     = 20;
	localparam int T1_BYTES    = 8;
	localparam int T2_ROUNDS   = 10;
	localparam int T2_BYTES    = 6;
	localparam int INJ_FRAMES  = 4;
	localparam int BURST_LEN   = 20;
	localparam int CLR_BYTES   = 6;
	localparam int N_FRAMES    = T1_BYTES + T2_ROUNDS * T2_BYTES + INJ_FRAMES + BURST_LEN
		+ CLR_BYTES;
	// 12 bit periods covers the longest frame
	localparam int WD_TIME     = N_FRAMES * 12 * (MAX_DIV + 1) * CLK_PERIOD + 100000;
	localparam int WAIT_LIMIT  = 48 * (MAX_DIV + 1);

	logic      clk = 1'b0;
	logic      rst;
	logic      wr;
	byte_t     tx_data;
	logic      rd;
	logic      clr;
	logic      parity_en;
	logic      odd;
	logic      size8;
	logic      stop2;
	baud_div_t baud_div;
	logic      rx_serial;
	logic      tx_serial;
	logic      tx_full;
	logic      rx_exist;
	byte_t     rx_data;
	logic      rx_perr;
	integer    seed = 32'hdf03;
	logic      inject_sel;  // 0 loops the transmitter back
	logic      inj_line;
	logic      mon_busy = 1'b0;
	logic      full_seen;

	`include "uart_model.svh"

	assign rx_serial = inject_sel ? inj_line : tx_serial;

	uart_top #(
		.FIFO_ADDR_W(FIFO_ADDR_W)
	) u_dut (
		.clk        (clk),
		.rst        (rst),
		.i_wr       (wr),
		.i_tx_data  (tx_data),
		.i_rd       (rd),
		.i_clr      (clr),
		.i_parity_en(parity_en),
		.i_odd      (odd),
		.i_size8    (size8),
		.i_stop2    (stop2),
		.i_baud_div (baud_div),
		.i_rx_serial(rx_serial),
		.o_tx_serial(tx_serial),
		.o_tx_full  (tx_full),
		.o_rx_exist (rx_exist),
		.o_rx_data  (rx_data),
		.o_rx_perr  (rx_perr)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic wait_cycles(int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	function automatic logic rand_bit();
		return ($random(seed) & 1) != 0;
	endfunction

	function automatic baud_div_t rand_div();
		return baud_div_t'(3 + ({$random(seed)} % 18));
	endfunction

	task automatic set_config(logic pe, logic od, logic s8, logic s2, baud_div_t bd);
		parity_en = pe;
		odd       = od;
		size8     = s8;
		stop2     = s2;
		baud_div  = bd;
		wait_cycles(1);
	endtask

	task automatic write_byte(byte_t d);
		if (!tx_full) begin
			note_write(d);
		end else begin
			full_seen = 1'b1;  // this write is dropped
		end
		wr      = 1'b1;
		tx_data = d;
		wait_cycles(1);
		wr = 1'b0;
	endtask

	task automatic send_bytes(int n, bit back_to_back);
		int gap;
		for (int i = 0; i < n; i++) begin
			write_byte(byte_t'($random(seed)));
			gap = back_to_back ? 0 : {$random(seed)} % 4;
			wait_cycles(gap);
		end
	endtask

	// start bit is due within baud_div+3 cycles of the write
	task automatic timed_write(byte_t d);
		int n;
		write_byte(d);
		n = 1;
		while (tx_serial && n < baud_div + 3) begin
			wait_cycles(1);
			n++;
		end
		check_bit("o_tx_serial start", tx_serial, ~LINE_IDLE);
	endtask

	task automatic read_word(output rx_word_t w, output bit ok);
		int n;
		n = 0;
		while (!rx_exist && n < WAIT_LIMIT) begin
			wait_cycles(1);
			n++;
		end
		ok = rx_exist;
		w  = {rx_perr, rx_data};
		if (!ok) begin
			err_cnt++;
			$display("error at %0t ns: no received word arrived in time", $time);
		end else begin
			rd = 1'b1;
			wait_cycles(1);
			rd = 1'b0;
			wait_cycles(2);  // next head entry
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while ((line_q.size() != 0 || mon_busy) && n < WAIT_LIMIT) begin
			wait_cycles(1);
			n++;
		end
		if (line_q.size() != 0 || mon_busy) begin
			err_cnt++;
			$display("error at %0t ns: transmit line never went idle", $time);
			line_q.delete();
		end
		wait_cycles(3 * (baud_div + 1) + 4);  // receiver done with stop bits
		check_bit("o_tx_serial", tx_serial, LINE_IDLE);
	endtask

	task automatic drain_rx();
		rx_word_t w;
		bit       ok;
		ok = 1'b1;
		while (exp_q.size() != 0 && ok) begin
			read_word(w, ok);
			if (ok) begin
				check_word(w);
			end
		end
		exp_q.delete();
		wait_idle();
		check_bit("o_rx_exist", rx_exist, 1'b0);
	endtask

	task automatic inject_frame(byte_t d, bit flip);
		logic [11:0] bits;
		int          n;
		build_frame(d, flip, bits, n);
		exp_q.push_back({flip & parity_en, mask_data(d)});
		for (int i = 0; i < n; i++) begin
			inj_line = bits[i];
			wait_cycles(baud_div + 1);
		end
		inj_line = LINE_IDLE;
	endtask

	// decodes every frame on o_tx_serial at mid-bit
	initial begin : line_monitor
		byte_t exp_d;
		int    p;
		forever begin
			@(negedge tx_serial);
			mon_busy = 1'b1;
			p        = baud_div + 1;
			exp_d    = 8'h00;
			if (line_q.size() != 0) begin
				exp_d = line_q.pop_front();
			end else begin
				err_cnt++;
				$display("error at %0t ns: start bit on o_tx_serial with nothing written",
					$time);
			end
			repeat (p / 2) @(negedge clk);
			check_bit("o_tx_serial start", tx_serial, ~LINE_IDLE);
			for (int i = 0; i < (size8 ? 8 : 7); i++) begin
				repeat (p) @(negedge clk);
				check_bit($sformatf("o_tx_serial data[%0d]", i), tx_serial, exp_d[i]);
			end
			if (parity_en) begin
				repeat (p) @(negedge clk);
				check_bit("o_tx_serial parity", tx_serial, par_bit(exp_d));
			end
			for (int i = 0; i < 1 + stop2; i++) begin
				repeat (p) @(negedge clk);
				check_bit("o_tx_serial stop", tx_serial, LINE_IDLE);
			end
			mon_busy = 1'b0;
		end
	end

	initial begin : watchdog
		#(WD_TIME);
		$display("watchdog expired before the tests finished");
		$display("%0d checks, %0d errors", n_checks, err_cnt + 1);
		$display("tests failed");
		$finish;
	end

	initial begin : main
		rst        = 1'b0;
		wr         = 1'b0;
		tx_data    = 8'h00;
		rd         = 1'b0;
		clr        = 1'b0;
		parity_en  = 1'b0;
		odd        = 1'b0;
		size8      = 1'b1;
		stop2      = 1'b0;
		baud_div   = baud_div_t'(3);
		inject_sel = 1'b0;
		inj_line   = LINE_IDLE;
		full_seen  = 1'b0;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b1;
		wait_cycles(1);
		check_bit("o_tx_serial", tx_serial, LINE_IDLE);
		check_bit("o_tx_full", tx_full, 1'b0);
		check_bit("o_rx_exist", rx_exist, 1'b0);

		// loopback 8N1
		set_config(1'b0, 1'b0, 1'b1, 1'b0, rand_div());
		send_bytes(T1_BYTES, 1'b0);
		drain_rx();

		// loopback over random frame formats
		for (int r = 0; r < T2_ROUNDS; r++) begin
			set_config(rand_bit(), rand_bit(), rand_bit(), rand_bit(), rand_div());
			send_bytes(T2_BYTES, 1'b0);
			drain_rx();
		end

		// bad parity on every other injected frame
		set_config(1'b1, rand_bit(), rand_bit(), rand_bit(), rand_div());
		inject_sel = 1'b1;
		for (int i = 0; i < INJ_FRAMES; i++) begin
			inject_frame(byte_t'($random(seed)), (i % 2) == 0);
		end
		drain_rx();
		inject_sel = 1'b0;

		// write every cycle until the transmit FIFO fills
		set_config(rand_bit(), rand_bit(), 1'b1, rand_bit(), rand_div());
		full_seen = 1'b0;
		send_bytes(BURST_LEN, 1'b1);
		check_bit("o_tx_full", full_seen, 1'b1);
		drain_rx();

		// clear with data waiting in the receive FIFO
		set_config(rand_bit(), rand_bit(), rand_bit(), rand_bit(), rand_div());
		send_bytes(CLR_BYTES / 2, 1'b0);
		wait_idle();
		check_bit("o_rx_exist", rx_exist, 1'b1);
		clr = 1'b1;
		wait_cycles(1);
		clr = 1'b0;
		exp_q.delete();
		wait_cycles(1);
		check_bit("o_rx_exist", rx_exist, 1'b0);
		timed_write(byte_t'($random(seed)));
		send_bytes(CLR_BYTES / 2 - 1, 1'b0);
		drain_rx();

		$display("%0d checks, %0d errors", n_checks, err_cnt);
		if (err_cnt == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: source/uart_top.sv
`timescale 1ns/1ns

module uart_top #(
	parameter int FIFO_ADDR_W = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                i_wr,
	input  uart_pkg::byte_t     i_tx_data,
	input  logic                i_rd,
	input  logic                i_clr,
	input  logic                i_parity_en,
	input  logic                i_odd,
	input  logic                i_size8,
	input  logic                i_stop2,
	input  uart_pkg::baud_div_t i_baud_div,
	input  logic                i_rx_serial,
	output logic                o_tx_serial,
	output logic                o_tx_full,
	output logic                o_rx_exist,
	output uart_pkg::byte_t     o_rx_data,
	output logic                o_rx_perr
);

	import uart_pkg::*;

	byte_t    tx_head;
	logic     tx_empty;
	logic     tx_pop;
	logic     rx_push;
	rx_word_t rx_word;
	rx_word_t rx_head;
	logic     rx_empty;

	sync_fifo #(
		.FIFO_ADDR_W(FIFO_ADDR_W),
		.DATA_W     ($bits(byte_t))
	) u_tx_fifo (
		.clk    (clk),
		.rst    (rst),
		.i_wr   (i_wr),
		.i_rd   (tx_pop),
		.i_clr  (i_clr),
		.i_data (i_tx_data),
		.o_data (tx_head),
		.o_full (o_tx_full),
		.o_empty(tx_empty)
	);

	uart_tx_framer u_tx_framer (
		.clk         (clk),
		.rst         (rst),
		.i_fifo_empty(tx_empty),
		.i_fifo_data (tx_head),
		.i_parity_en (i_parity_en),
		.i_odd       (i_odd),
		.i_size8     (i_size8),
		.i_stop2     (i_stop2),
		.i_baud_div  (i_baud_div),
		.o_fifo_pop  (tx_pop),
		.o_tx_serial (o_tx_serial)
	);

	uart_rx_sampler u_rx_sampler (
		.clk        (clk),
		.rst        (rst),
		.i_rx_serial(i_rx_serial),
		.i_parity_en(i_parity_en),
		.i_odd      (i_odd),
		.i_size8    (i_size8),
		.i_baud_div (i_baud_div),
		.o_push     (rx_push),
		.o_word     (rx_word)
	);

	// pushes into a full FIFO are lost
	sync_fifo #(
		.FIFO_ADDR_W(FIFO_ADDR_W),
		.DATA_W     ($bits(rx_word_t))
	) u_rx_fifo (
		.clk    (clk),
		.rst    (rst),
		.i_wr   (rx_push),
		.i_rd   (i_rd),
		.i_clr  (i_clr),
		.i_data (rx_word),
		.o_data (rx_head),
		.o_full (),
		.o_empty(rx_empty)
	);

	assign o_rx_exist = ~rx_empty;
	assign o_rx_perr  = rx_head[8];
	assign o_rx_data  = rx_head[7:0];

endmodule

// File: source/uart_rx_sampler.sv
`timescale 1ns/1ns

module uart_rx_sampler (
	input  logic                clk,
	input  logic                rst,
	input  logic                i_rx_serial,
	input  logic                i_parity_en,
	input  logic                i_odd,
	input  logic                i_size8,
	input  uart_pkg::baud_div_t i_baud_div,
	output logic                o_push,
	output uart_pkg::rx_word_t  o_word
);

	import uart_pkg::*;

	logic [2:0] rx_sync;    // [1] is the synchronized line
	baud_div_t  div_cnt;
	logic [3:0] rcv_cnt;    // samples left, zero when idle
	logic [8:0] rx_shift;
	logic       par_acc;
	logic       last_d;
	logic       rx_bit;
	logic       fall_edge;
	logic       rcv_idle;
	logic       rcv_last;
	logic       div_zero;
	logic [1:0] data_w;     // extra bits above 7
	logic [3:0] sample_cnt;
	logic       perr;
	byte_t      rx_byte;

	assign rx_bit    = rx_sync[1];
	assign fall_edge = rx_sync[2] & ~rx_sync[1];
	assign rcv_idle  = (rcv_cnt == 4'd0);
	assign rcv_last  = (rcv_cnt == 4'd1); // only the stop bit is left
	assign div_zero  = (div_cnt == '0);

	assign data_w     = {1'b0, i_parity_en} + {1'b0, i_size8};
	assign sample_cnt = 4'd9 + {3'd0, i_parity_en} + {3'd0, i_size8};

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rx_sync <= RX_SYNC_RST;
			last_d  <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[1:0], i_rx_serial};
			last_d  <= rcv_last;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			div_cnt <= '0;
			rcv_cnt <= '0;
			par_acc <= 1'b0;
		end else if (rcv_idle) begin
			if (fall_edge) begin
				div_cnt <= i_baud_div >> 1; // aim at mid-bit
				rcv_cnt <= sample_cnt;
				par_acc <= 1'b0;
			end
		end else if (div_zero) begin
			div_cnt <= i_baud_div;
			rcv_cnt <= rcv_cnt - 4'd1;
			par_acc <= par_acc ^ rx_bit;
		end else begin
			div_cnt <= div_cnt - 1'b1;
		end
	end

	// shift window narrows with the data size and parity
	always_ff @(posedge clk) begin
		if (!rcv_idle && div_zero) begin
			rx_shift <= {rx_bit,
				(data_w == 2'd1) ? rx_bit : rx_shift[8],
				(data_w == 2'd0) ? rx_bit : rx_shift[7],
				rx_shift[6:1]};
		end
	end

	assign rx_byte = {i_size8 ? rx_shift[7] : 1'b0, rx_shift[6:0]};
	assign perr    = i_parity_en & (i_odd ^ par_acc);

	assign o_push = rcv_last & ~last_d;
	assign o_word = {perr, rx_byte};

	a_push_single: assert property (
		@(posedge clk) disable iff (!rst) o_push |=> !o_push
	);

endmodule

// File: source/uart_tx_framer.sv
`timescale 1ns/1ns

module uart_tx_framer (
	input  logic                clk,
	input  logic                rst,
	input  logic                i_fifo_empty,
	input  uart_pkg::byte_t     i_fifo_data,
	input  logic                i_parity_en,
	input  logic                i_odd,
	input  logic                i_size8,
	input  logic                i_stop2,
	input  uart_pkg::baud_div_t i_baud_div,
	output logic                o_fifo_pop,
	output logic                o_tx_serial
);

	import uart_pkg::*;

	baud_div_t  div_cnt;    // bit timer, counts down
	logic [3:0] bits_left;  // line bits still to shift out
	logic [8:0] tx_sreg;
	logic       par_acc;    // xor of data bits sent so far
	logic       tx_active;
	logic       timer_zero;
	logic       par_slot;
	logic       next_bit;
	logic [3:0] frame_len;

	assign tx_active  = (bits_left != 4'd0);
	assign timer_zero = (div_cnt == '0);

	// bit wraps after the start bit
	assign frame_len = 4'd8 + {3'd0, i_parity_en} + {3'd0, i_size8} + {3'd0, i_stop2};

	// parity goes out right before the stop bits
	assign par_slot = i_parity_en & (bits_left == (4'd2 + {3'd0, i_stop2}));
	assign next_bit = par_slot ? (i_odd ^ par_acc) : tx_sreg[1];

	assign o_fifo_pop  = ~i_fifo_empty & ~tx_active & timer_zero;
	assign o_tx_serial = tx_sreg[0];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			div_cnt   <= '0;
			bits_left <= '0;
			tx_sreg   <= TX_SREG_RST;
			par_acc   <= 1'b0;
		end else if (o_fifo_pop) begin
			div_cnt   <= i_baud_div;
			bits_left <= frame_len;
			par_acc   <= 1'b0;
			// stop level fills bit 7 in 7-bit mode
			tx_sreg   <= {i_size8 ? i_fifo_data[7] : LINE_IDLE, i_fifo_data[6:0], ~LINE_IDLE};
		end else if (tx_active || !timer_zero) begin
			if (timer_zero) begin
				div_cnt   <= i_baud_div;
				bits_left <= bits_left - 4'd1;
				par_acc   <= par_acc ^ tx_sreg[1];
				tx_sreg   <= {LINE_IDLE, tx_sreg[8:2], next_bit};
			end else begin
				div_cnt <= div_cnt - 1'b1;
			end
		end
	end

	// all frame bits shifted out leaves the line at idle level
	a_idle_line_high: assert property (
		@(posedge clk) disable iff (!rst) !tx_active |-> o_tx_serial
	);

endmodule

// File: source/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
	parameter int FIFO_ADDR_W = 4,
	parameter int DATA_W      = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_wr,
	input  logic              i_rd,
	input  logic              i_clr,
	input  logic [DATA_W-1:0] i_data,
	output logic [DATA_W-1:0] o_data,
	output logic              o_full,
	output logic              o_empty
);

	localparam int DEPTH = 2 ** FIFO_ADDR_W;

	logic [DATA_W-1:0]    mem [DEPTH];
	logic [FIFO_ADDR_W:0] wr_ptr;      // one extra bit for wrap
	logic [FIFO_ADDR_W:0] rd_ptr;
	logic [FIFO_ADDR_W:0] level;
	logic                 empty_now;
	logic                 empty_d;     // covers registered read latency
	logic                 do_wr;
	logic                 do_rd;

	assign level     = wr_ptr - rd_ptr;
	assign empty_now = (level == '0);
	assign o_empty   = empty_now | empty_d;
	assign o_full    = level[FIFO_ADDR_W];
	assign do_wr     = i_wr & ~o_full;
	assign do_rd     = i_rd & ~o_empty;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			empty_d <= 1'b1;
		end else begin
			empty_d <= empty_now;
			if (i_clr) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
			end else begin
				if (do_wr) begin
					wr_ptr <= wr_ptr + 1'b1;
				end
				if (do_rd) begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr && !i_clr) begin
			mem[wr_ptr[FIFO_ADDR_W-1:0]] <= i_data;
		end
		o_data <= mem[rd_ptr[FIFO_ADDR_W-1:0]]; // head entry
	end

	a_level_in_range: assert property (
		@(posedge clk) disable iff (!rst) level <= DEPTH
	);

	a_not_full_and_empty: assert property (
		@(posedge clk) disable iff (!rst) !(o_full && o_empty)
	);

endmodule

// File: source/uart_pkg.sv
package uart_pkg;

	localparam int BAUD_DIV_W = 8;

	// host data byte
	typedef logic [7:0] byte_t;

	// bit period minus one
	typedef logic [BAUD_DIV_W-1:0] baud_div_t;

	// parity error flag above the received byte
	typedef logic [8:0] rx_word_t;

	localparam logic LINE_IDLE = 1'b1;

	// framer shift register idles at line level
	localparam logic [8:0] TX_SREG_RST = {9{LINE_IDLE}};

	// synchronizer starts at idle so no false start edge
	localparam logic [2:0] RX_SYNC_RST = {3{LINE_IDLE}};

endpackage
